/* read_reorder_unit.f */
reorder_pkg.sv
dualport_ram.sv
reorder_scoreboard.sv
request_issue.sv
response_drain.sv
read_reorder_unit.sv
tb_read_reorder_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; a $fatal gives a failing exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f read_reorder_unit.f \
    --top-module tb_read_reorder_unit -o sim_read_reorder_unit &&
./obj_dir/sim_read_reorder_unit ||
{
    echo "simulation run reported an error"
    exit 1
}

/* tb_read_reorder_unit.sv */
// ******************************
// Testbench for the read reorder unit. Client driver, out-of-order memory
// model, reference queue and assertions
// ******************************
`timescale 1ns/1ps
`default_nettype none

module tb_read_reorder_unit
    import reorder_pkg::*;
;

    localparam int RESET_CYCLES = 16;
    localparam int CAPACITY = N_ENTRIES - MIN_FREE_SLOTS;
    localparam int CAP_REQS = CAPACITY + 5;
    localparam int CAP_WAIT = 40;
    localparam int RAND_REQS = 300;
    localparam int TOTAL_REQS = CAP_REQS + RAND_REQS;
    localparam logic [31:0] SEED = 32'hb767_47a1;

    // Memory model modes
    localparam int MEM_HOLD = 0;
    localparam int MEM_REVERSE = 1;
    localparam int MEM_RANDOM = 2;

    logic     clk = 1'b0;
    logic     reset_n;
    rd_req_t  req;
    logic     req_valid;
    logic     req_ready;
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_valid;
    rd_rsp_t  rsp;
    logic     rsp_valid;
    logic     rsp_ready;

    // Reference queue of accepted client requests, oldest first
    rd_req_t  ref_q[$];
    // Memory requests seen by the model and not yet answered
    mem_req_t pending[$];

    logic [31:0]          rng;
    logic [N_ENTRIES-1:0] idx_busy;
    rd_rsp_t              exp_rsp;
    logic                 exp_valid;
    int                   in_flight;
    int                   to_send;
    int                   mem_mode;
    logic                 stalls;
    logic                 gaps;
    int                   total_acc;
    int                   total_mreq;
    int                   total_rsp;

    // Handshakes seen at the falling edge, used after the next rising edge
    logic     req_fire_s;
    logic     mreq_fire_s;
    logic     rsp_fire_s;
    mem_req_t mreq_s;

    read_reorder_unit UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failed check");
    endtask

    always @(negedge clk)
    begin
        req_fire_s  <= req_valid && req_ready;
        mreq_fire_s <= mem_req_valid && mem_req_ready;
        rsp_fire_s  <= rsp_valid && rsp_ready;
        mreq_s      <= mem_req;
    end

    // Outputs only move on the rising edge, so all checks sample at the falling edge
    reset_state_check: assert property (@(negedge clk)
        $rose(reset_n) |-> !rsp_valid && !mem_req_valid && req_ready)
        else report_mismatch("outputs wrong right after reset");

    order_check: assert property (@(negedge clk) disable iff (!reset_n)
        rsp_valid && rsp_ready |-> exp_valid && (rsp == exp_rsp))
        else report_mismatch("response differs from oldest reference entry");

    rsp_hold_check: assert property (@(negedge clk) disable iff (!reset_n)
        $past(rsp_valid && !rsp_ready) |-> rsp_valid && (rsp == $past(rsp)))
        else report_mismatch("rsp changed while stalled");

    mem_req_hold_check: assert property (@(negedge clk) disable iff (!reset_n)
        $past(mem_req_valid && !mem_req_ready) |-> mem_req_valid && (mem_req == $past(mem_req)))
        else report_mismatch("mem_req changed while stalled");

    capacity_check: assert property (@(negedge clk) disable iff (!reset_n)
        (mem_mode == MEM_HOLD) && (in_flight >= CAPACITY) |-> !req_ready)
        else report_mismatch("request accepted beyond scoreboard capacity");

    index_reuse_check: assert property (@(negedge clk) disable iff (!reset_n)
        mem_req_valid && mem_req_ready |-> !idx_busy[mem_req.idx])
        else report_mismatch("slot index reissued before its data returned");

    // Book-keeping of the transfers that took place on the last rising edge
    task automatic record_transfers();
        if (req_fire_s)
        begin
            ref_q.push_back(req);
            total_acc++;
        end
        if (mreq_fire_s)
        begin
            pending.push_back(mreq_s);
            idx_busy[mreq_s.idx] = 1'b1;
            total_mreq++;
        end
        if (rsp_fire_s)
        begin
            ref_q.delete(0);
            total_rsp++;
        end
        exp_valid = (ref_q.size() > 0);
        if (exp_valid)
        begin
            // Memory data is the address over its inverse
            exp_rsp = '{data: {ref_q[0].addr, ~ref_q[0].addr}, meta: ref_q[0].meta};
        end
        in_flight = ref_q.size();
    endtask

    task automatic drive_inputs();
        int       pick;
        mem_req_t p;
        // A request that was not taken stays on the bus unchanged
        if (!req_valid || req_fire_s)
        begin
            req_valid = 1'b0;
            if (to_send > 0)
            begin
                rng = xorshift32(rng);
                if (!gaps || rng[1:0] != 2'b00)
                begin
                    req_valid = 1'b1;
                    req = '{addr: rng[31:16], meta: rng[3:0]};
                    to_send--;
                end
            end
        end
        mem_rsp_valid = 1'b0;
        if (pending.size() > 0 && mem_mode != MEM_HOLD)
        begin
            rng = xorshift32(rng);
            if (mem_mode == MEM_REVERSE || rng[9:8] != 2'b00)
            begin
                if (mem_mode == MEM_REVERSE)
                begin
                    pick = pending.size() - 1;
                end
                else
                begin
                    pick = int'(rng % pending.size());
                end
                p = pending[pick];
                pending.delete(pick);
                idx_busy[p.idx] = 1'b0;
                mem_rsp = '{idx: p.idx, data: {p.addr, ~p.addr}};
                mem_rsp_valid = 1'b1;
            end
        end
        mem_req_ready = 1'b1;
        rsp_ready = 1'b1;
        if (stalls)
        begin
            rng = xorshift32(rng);
            mem_req_ready = (rng[2:0] >= 3'd2);
            rsp_ready = (rng[6:4] >= 3'd3);
        end
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        #1;
        record_transfers();
        drive_inputs();
    endtask

    task automatic drain_traffic();
        while (to_send > 0 || req_valid || ref_q.size() > 0 || pending.size() > 0)
        begin
            advance_cycle();
        end
    endtask

    initial
    begin
        reset_n = 1'b0;
        req = '0;
        req_valid = 1'b0;
        mem_req_ready = 1'b1;
        mem_rsp = '0;
        mem_rsp_valid = 1'b0;
        rsp_ready = 1'b1;
        rng = SEED;
        idx_busy = '0;
        exp_rsp = '0;
        exp_valid = 1'b0;
        in_flight = 0;
        to_send = 0;
        mem_mode = MEM_HOLD;
        stalls = 1'b0;
        gaps = 1'b0;
        total_acc = 0;
        total_mreq = 0;
        total_rsp = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Memory holds every answer, so only the free slots can be taken
        to_send = CAP_REQS;
        repeat (CAP_WAIT) advance_cycle();
        assert (total_acc == CAPACITY)
        else report_mismatch("wrong number of requests accepted with memory silent");

        // Answer the held batch newest first
        mem_mode = MEM_REVERSE;
        drain_traffic();

        // Random answer order with gaps and stalls on both ready inputs
        mem_mode = MEM_RANDOM;
        stalls = 1'b1;
        gaps = 1'b1;
        to_send = RAND_REQS;
        drain_traffic();
        // Every request must reach memory once and come back to the client once
        assert (total_mreq == TOTAL_REQS && total_rsp == TOTAL_REQS)
        else report_mismatch("memory request or response count differs from requests sent");

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Each request gets a generous cycle budget before the run is called hung
    initial
    begin
        repeat (RESET_CYCLES + TOTAL_REQS * 200) @(posedge clk);
        $display("Watchdog timeout: traffic did not drain in the allowed cycles");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* read_reorder_unit.sv */
// ******************************
// Read reorder unit top. Issue stage, scoreboard and output drain stage
// ******************************
`timescale 1ns/1ps
`default_nettype none

module read_reorder_unit
    import reorder_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,

    // Client request
    input  rd_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,

    // Memory request
    output mem_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,

    // Memory response, any order, always accepted
    input  mem_rsp_t mem_rsp,
    input  logic     mem_rsp_valid,

    // Client response in request order
    output rd_rsp_t  rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready
);

    // Issue stage to scoreboard
    logic                 alloc_en;
    logic [META_BITS-1:0] alloc_meta;
    idx_t                 alloc_idx;
    logic                 not_full;

    // Scoreboard to drain stage
    logic    deq_en;
    logic    not_empty;
    rd_rsp_t head;

    request_issue issue (
        .clk           (clk),
        .reset_n       (reset_n),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .not_full      (not_full),
        .alloc_idx     (alloc_idx),
        .alloc_en      (alloc_en),
        .alloc_meta    (alloc_meta),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready)
    );

    // Memory responses write straight into the scoreboard
    reorder_scoreboard scoreboard (
        .clk        (clk),
        .reset_n    (reset_n),
        .alloc_en   (alloc_en),
        .alloc_meta (alloc_meta),
        .not_full   (not_full),
        .alloc_idx  (alloc_idx),
        .data_en    (mem_rsp_valid),
        .data_rsp   (mem_rsp),
        .deq_en     (deq_en),
        .not_empty  (not_empty),
        .head       (head)
    );

    response_drain drain (
        .clk       (clk),
        .reset_n   (reset_n),
        .not_empty (not_empty),
        .head      (head),
        .deq_en    (deq_en),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

endmodule

`default_nettype wire

/* response_drain.sv */
// ******************************
// Output stage. Dequeues the oldest complete entry into a register and
// holds it while the client stalls
// ******************************
`timescale 1ns/1ps
`default_nettype none

module response_drain
    import reorder_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,

    // Scoreboard head
    input  logic    not_empty,
    input  rd_rsp_t head,
    output logic    deq_en,

    // Ordered client response
    output rd_rsp_t rsp,
    output logic    rsp_valid,
    input  logic    rsp_ready
);

    logic out_free;

    // A new entry can be loaded when the register is empty or
    // is handed to the client in this cycle
    assign out_free = !rsp_valid || rsp_ready;
    assign deq_en = not_empty && out_free;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_valid <= 1'b0;
        end
        else if (deq_en)
        begin
            rsp_valid <= 1'b1;
        end
        else if (rsp_ready)
        begin
            rsp_valid <= 1'b0;
        end
    end

    // Payload only changes on a dequeue, so it stays put under a stall
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            rsp <= head;
        end
    end

endmodule

`default_nettype wire

/* request_issue.sv */
// ******************************
// Issue stage. Takes client reads, allocates a slot and holds the tagged
// memory request until the memory accepts it
// ******************************
`timescale 1ns/1ps
`default_nettype none

module request_issue
    import reorder_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,

    // Client request
    input  rd_req_t              req,
    input  logic                 req_valid,
    output logic                 req_ready,

    // Scoreboard allocation
    input  logic                 not_full,
    input  idx_t                 alloc_idx,
    output logic                 alloc_en,
    output logic [META_BITS-1:0] alloc_meta,

    // Memory request
    output mem_req_t             mem_req,
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready
);

    issue_state_t state;
    mem_req_t     held;

    logic hold_free;
    logic accept;

    // The holding register can be refilled in the cycle it is emptied
    assign hold_free = (state == ISSUE_EMPTY) || mem_req_ready;
    assign req_ready = hold_free && not_full;
    assign accept = req_valid && req_ready;

    // The slot is allocated in the cycle the client request is taken
    assign alloc_en = accept;
    assign alloc_meta = req.meta;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ISSUE_EMPTY;
        end
        else if (accept)
        begin
            state <= ISSUE_HELD;
        end
        else if (mem_req_ready)
        begin
            state <= ISSUE_EMPTY;
        end
    end

    // Address and its new slot index travel together to memory
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            held <= '{idx: alloc_idx, addr: req.addr};
        end
    end

    assign mem_req = held;
    assign mem_req_valid = (state == ISSUE_HELD);

endmodule

`default_nettype wire

/* reorder_scoreboard.sv */
// ******************************
// Reorder scoreboard. Hands out ring slots in order, sorts late data in by
// slot index and presents the oldest entry once its data is present
// ******************************
`timescale 1ns/1ps
`default_nettype none

module reorder_scoreboard
    import reorder_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,

    // Slot allocation, meta is stored with the new slot
    input  logic                 alloc_en,
    input  logic [META_BITS-1:0] alloc_meta,
    output logic                 not_full,
    output idx_t                 alloc_idx,

    // Data arrival by slot index; there is no ready, data is always taken
    input  logic                 data_en,
    input  mem_rsp_t             data_rsp,

    // Ordered output of the oldest entry
    input  logic                 deq_en,
    output logic                 not_empty,
    output rd_rsp_t              head
);

    // Pointer space with one extra bit for comparing wrapped pointers
    typedef logic [IDX_BITS:0] ptr_ext_t;

    idx_t newest;
    idx_t oldest;
    idx_t oldest_next;
    idx_t oldest_plus1;

    logic newest_ge_oldest;

    logic [DATA_BITS-1:0] data_rd;
    logic [META_BITS-1:0] meta_rd;

    // Arrival bits, next value and registered copy
    logic [N_ENTRIES-1:0] arrived;
    logic [N_ENTRIES-1:0] arrived_q;

    // Arrival bits of head and the entry after it, taken last cycle
    logic [1:0] head_arrived_q;
    logic       deq_en_q;

    // Delayed reset for the wide arrival vector
    logic reset_n_q;

    // Free space is judged with MIN_FREE_SLOTS held in reserve. When newest
    // has wrapped below oldest, oldest is compared without the extra bit
    assign newest_ge_oldest = (newest >= oldest);
    assign not_full = (ptr_ext_t'({1'b0, newest}) + ptr_ext_t'(MIN_FREE_SLOTS)) <
                      ptr_ext_t'({newest_ge_oldest, oldest});

    // A new entry always goes to the newest slot
    assign alloc_idx = newest;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            newest <= '0;
        end
        else if (alloc_en)
        begin
            newest <= newest + idx_t'(1);
        end
    end

    // Oldest moves on by one for each dequeue
    assign oldest_next = oldest + idx_t'(deq_en);
    assign oldest_plus1 = oldest + idx_t'(1);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            oldest <= '0;
        end
        else
        begin
            oldest <= oldest_next;
        end
    end

    // Both RAMs are read at the pointer oldest will hold next cycle, so the
    // head word is ready by the time not_empty can rise for it
    dualport_ram #(
        .WIDTH (DATA_BITS)
    ) data_ram (
        .clk   (clk),
        .wen   (data_en),
        .waddr (data_rsp.idx),
        .wdata (data_rsp.data),
        .raddr (oldest_next),
        .rdata (data_rd)
    );

    // Meta comes in at allocation time with the slot index
    dualport_ram #(
        .WIDTH (META_BITS)
    ) meta_ram (
        .clk   (clk),
        .wen   (alloc_en),
        .waddr (newest),
        .wdata (alloc_meta),
        .raddr (oldest_next),
        .rdata (meta_rd)
    );

    assign head = '{data: data_rd, meta: meta_rd};

    // Clear the head bit on dequeue and set a bit on data arrival
    always_comb
    begin
        arrived = arrived_q;
        if (deq_en)
        begin
            arrived[oldest] = 1'b0;
        end
        if (data_en)
        begin
            arrived[data_rsp.idx] = 1'b1;
        end
    end

    // Nothing can be dequeued in the first cycle out of reset, so the
    // arrival state may come out of reset a cycle late
    always_ff @(posedge clk)
    begin
        reset_n_q <= reset_n;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n_q)
        begin
            arrived_q      <= '0;
            head_arrived_q <= 2'b00;
            deq_en_q       <= 1'b0;
        end
        else
        begin
            arrived_q <= arrived;
            // Keep only the two bits that can be the head next cycle
            head_arrived_q <= {arrived_q[oldest_plus1], arrived_q[oldest]};
            deq_en_q       <= deq_en;
        end
    end

    // If the head was dequeued last cycle, the entry after it is now head
    assign not_empty = head_arrived_q[deq_en_q];

endmodule

`default_nettype wire

/* dualport_ram.sv */
// ******************************
// Scoreboard storage with one write port and one registered read port
// ******************************
`timescale 1ns/1ps
`default_nettype none

module dualport_ram
    import reorder_pkg::*;
#(
    parameter int WIDTH = DATA_BITS
)
(
    input  logic             clk,

    // Write port, used when data or meta is stored by slot index
    input  logic             wen,
    input  idx_t             waddr,
    input  logic [WIDTH-1:0] wdata,

    // Read port; the word shows up the cycle after raddr is presented
    input  idx_t             raddr,
    output logic [WIDTH-1:0] rdata
);

    // One word per scoreboard slot
    logic [WIDTH-1:0] mem [N_ENTRIES];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // A read of the address being written returns the old word, and the
    // new word follows one cycle later since raddr is read every cycle
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* reorder_pkg.sv */
// ******************************
// Read reorder unit shared sizes, slot index type, port structs and the
// issue stage state encoding
// ******************************
`default_nettype none

package reorder_pkg;

    // Scoreboard depth; must stay a power of two so the ring pointers wrap
    localparam int N_ENTRIES = 16;
    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // Client side widths
    localparam int ADDR_BITS = 16;
    localparam int DATA_BITS = 32;
    localparam int META_BITS = 4;

    // Slots held back from allocation, so 15 of 16 can be outstanding
    localparam int MIN_FREE_SLOTS = 1;

    typedef logic [IDX_BITS-1:0] idx_t;

    // Read request as the client presents it
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [META_BITS-1:0] meta;
    } rd_req_t;

    // Read request tagged with its scoreboard slot, sent to memory
    typedef struct packed {
        idx_t                 idx;
        logic [ADDR_BITS-1:0] addr;
    } mem_req_t;

    // Memory answer; the slot index says where the data is sorted in
    typedef struct packed {
        idx_t                 idx;
        logic [DATA_BITS-1:0] data;
    } mem_rsp_t;

    // In-order response back to the client
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic [META_BITS-1:0] meta;
    } rd_rsp_t;

    // Holding register of the issue stage is either free or holds a request
    typedef enum logic {
        ISSUE_EMPTY,
        ISSUE_HELD
    } issue_state_t;

endpackage

`default_nettype wire
